//--- verilog.f
+incdir+design
design/operand_pkg.sv
design/pipe_pkg.sv
design/issue_if.sv
design/regfile.sv
design/operand_mux.sv
design/issue_queue.sv
design/operand_stage.sv
design/opfetch_top.sv
testbench/tb_opfetch.sv

//--- run_sim.sh
#!/bin/sh
# build and run with Verilator, the log decides pass or fail
rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal --top-module tb_opfetch -f verilog.f -o tb_opfetch &&
	./obj_dir/tb_opfetch > sim.log 2>&1 ||
	{ echo "build or simulation did not complete"; exit 1; }
cat sim.log
grep -qF "*** TEST FAILED ***" sim.log && { echo "simulation reported errors"; exit 1; } || exit 0

//--- testbench/tb_opfetch.sv
/* acts as issuer, execution unit and commit source around opfetch_top
   random stimulus from a 16-bit galois lfsr with a fixed seed */
`timescale 1ns/1ps
`include "opfetch_params.svh"

module tb_opfetch import operand_pkg::*, pipe_pkg::*;;

	localparam int DRAIN_TIMEOUT = 400;
	localparam int CREDIT_TIMEOUT = 200;

	typedef struct packed {
		reg_file_t	rs1;
		reg_file_t	rs2;
		imm_data_t	imm;
		data_t		pc;
		rob_id_t	tag;
	} pkt_t;

	// expected operand word and its active-low enable
	typedef struct packed {
		data_t	data;
		logic	data_e_;
	} exp_t;

	logic		clk;
	logic		rst;
	logic		issue_valid;
	reg_file_t	issue_rs1;
	reg_file_t	issue_rs2;
	imm_data_t	issue_imm;
	data_t		issue_pc;
	rob_id_t	issue_rob_id;
	logic		issue_credit;
	logic		wb_e_;
	rob_id_t	wb_rob_id;
	data_t		wb_data;
	logic		commit_e_;
	rob_id_t	commit_rob_id;
	reg_file_t	commit_rd;
	data_t		commit_data;
	logic		ex_credit;
	logic		ex_valid;
	rob_id_t	ex_rob_id;
	data_t		ex_data1;
	logic		ex_data1_e_;
	data_t		ex_data2;
	logic		ex_data2_e_;

	logic [15:0]	lfsr;
	data_t		gpr_shadow [`REG_COUNT];
	data_t		fpr_shadow [`REG_COUNT];
	pkt_t		pkt_q [$];
	exp_t		pend1;
	exp_t		pend2;
	rob_id_t	pend_tag;
	logic		have_pend = 1'b0;
	logic		ex_random = 1'b0;
	logic		byp_random = 1'b0;
	int			issue_credits = `ISSUE_DEPTH;
	int			ex_owed = 0;
	int			ex_sent = 0;
	int			ex_returned = 0;
	int			credit_pulses = 0;
	int			issued_total = 0;
	int			err_value = 0;
	int			err_other = 0;

	opfetch_top u_dut (
		.clk(clk), .rst(rst),
		.issue_valid(issue_valid), .issue_rs1(issue_rs1), .issue_rs2(issue_rs2),
		.issue_imm(issue_imm), .issue_pc(issue_pc), .issue_rob_id(issue_rob_id),
		.issue_credit(issue_credit),
		.wb_e_(wb_e_), .wb_rob_id(wb_rob_id), .wb_data(wb_data),
		.commit_e_(commit_e_), .commit_rob_id(commit_rob_id),
		.commit_rd(commit_rd), .commit_data(commit_data),
		.ex_credit(ex_credit), .ex_valid(ex_valid), .ex_rob_id(ex_rob_id),
		.ex_data1(ex_data1), .ex_data1_e_(ex_data1_e_),
		.ex_data2(ex_data2), .ex_data2_e_(ex_data2_e_)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	// one lfsr step per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			r = {r[30:0], lfsr[0]};
			lfsr = lfsr_next(lfsr);
		end
		return r;
	endfunction

	function automatic reg_file_t rand_src();
		reg_file_t rs;
		rs.regtype = reg_type_e'(3'(rand_bits(3) % 6));
		rs.addr = reg_addr_t'(rand_bits(5));
		return rs;
	endfunction

	function automatic imm_data_t rand_imm();
		imm_data_t imm;
		imm.data = 20'(rand_bits(20));
		imm.size = imm_size_e'(2'(rand_bits(2)));
		imm.shift = imm_shift_e'(2'(rand_bits(2) % 3));
		imm.sign = (rand_bits(1) != 0);
		return imm;
	endfunction

	// field width by size, upper bits filled from the field msb when signed
	function automatic data_t ref_imm(input imm_data_t imm);
		int width;
		int sh;
		data_t mask;
		data_t val;
		case (imm.size)
			IMM_SIZE5: width = 5;
			IMM_SIZE12: width = 12;
			default: width = 20;
		endcase
		mask = (data_t'(1) << width) - 1;
		val = data_t'(imm.data) & mask;
		if (imm.size != IMM_SIZE5_12 && imm.sign && val[width-1]) begin
			val = val | ~mask;
		end
		sh = 0;
		if (imm.size == IMM_SIZE12 && imm.shift == IMM_SHIFT1) begin
			sh = 1;
		end else if (imm.size == IMM_SIZE20) begin
			sh = (imm.shift == IMM_SHIFT1) ? 1 : 12;
		end
		return val << sh;
	endfunction

	// uses shadow files and the bypass inputs of the current cycle
	function automatic exp_t ref_operand(input reg_file_t rs, input imm_data_t imm,
		input data_t pc);
		exp_t r;
		r.data = '0;
		r.data_e_ = 1'b0;
		case (rs.regtype)
			TYPE_GPR: r.data = gpr_shadow[rs.addr];
			TYPE_FPR: r.data = fpr_shadow[rs.addr];
			TYPE_IMM: r.data = ref_imm(imm);
			TYPE_PC: r.data = pc;
			TYPE_ROB: begin
				if (!wb_e_ && rob_id_t'(rs.addr) == wb_rob_id) begin
					r.data = wb_data;
				end else if (!commit_e_ && rob_id_t'(rs.addr) == commit_rob_id) begin
					r.data = commit_data;
				end else begin
					r.data_e_ = 1'b1;
				end
			end
			default: r.data = '0;
		endcase
		return r;
	endfunction

	task automatic check_data(input string what, input data_t got, input data_t exp);
		if (got !== exp) begin
			$display("error at %0d ns: %s is %h, expected %h", $time, what, got, exp);
			err_value++;
		end
	endtask

	task automatic check_tag(input string what, input rob_id_t got, input rob_id_t exp);
		if (got !== exp) begin
			$display("error at %0d ns: %s is %0d, expected %0d", $time, what, got, exp);
			err_value++;
		end
	endtask

	task automatic check_enable(input string what, input logic got, input logic exp);
		if (got !== exp) begin
			$display("error at %0d ns: %s is %b, expected %b", $time, what, got, exp);
			err_value++;
		end
	endtask

	task automatic drive_random_bypass();
		rob_id_t wb_tag;
		reg_file_t rd;
		wb_tag = rob_id_t'(rand_bits(4));
		rd.regtype = reg_type_e'(3'(rand_bits(2) % 3));
		rd.addr = reg_addr_t'(rand_bits(5));
		wb_e_ <= (rand_bits(1) != 0);
		wb_rob_id <= wb_tag;
		wb_data <= rand_bits(32);
		commit_e_ <= (rand_bits(1) != 0);
		// offset of 1 to 8 keeps the commit tag off the writeback tag
		commit_rob_id <= wb_tag + rob_id_t'(1 + rand_bits(3));
		commit_rd <= rd;
		commit_data <= rand_bits(32);
	endtask

	// one clock of the issuer and the execution unit
	task automatic step();
		logic give;
		@(posedge clk);
		issue_valid <= 1'b0;
		give = (ex_owed > 0);
		if (give && ex_random) begin
			give = (rand_bits(1) != 0);
		end
		// a credit goes back only for a packet already taken
		if (give) begin
			ex_credit <= 1'b1;
			ex_owed--;
		end else begin
			ex_credit <= 1'b0;
		end
		if (byp_random) begin
			drive_random_bypass();
		end
	endtask

	task automatic issue_pkt(input pkt_t p);
		int waited;
		waited = 0;
		while (issue_credits == 0 && waited < CREDIT_TIMEOUT) begin
			step();
			waited++;
		end
		if (issue_credits == 0) begin
			$display("no issue credit came back within %0d cycles (at %0d ns)",
				CREDIT_TIMEOUT, $time);
			err_other++;
		end else begin
			step();
			issue_valid <= 1'b1;
			issue_rs1 <= p.rs1;
			issue_rs2 <= p.rs2;
			issue_imm <= p.imm;
			issue_pc <= p.pc;
			issue_rob_id <= p.tag;
			pkt_q.push_back(p);
			issue_credits--;
			issued_total++;
		end
	endtask

	task automatic commit_reg(input reg_type_e kind, input reg_addr_t waddr, input data_t value);
		step();
		commit_e_ <= 1'b0;
		commit_rd <= '{regtype: kind, addr: waddr};
		commit_rob_id <= '0;
		commit_data <= value;
		step();
		commit_e_ <= 1'b1;
		commit_rd <= '{regtype: TYPE_NONE, addr: '0};
	endtask

	task automatic wait_drain();
		int waited;
		waited = 0;
		while (pkt_q.size() != 0 && waited < DRAIN_TIMEOUT) begin
			step();
			waited++;
		end
		if (pkt_q.size() != 0) begin
			$display("%0d packets never left the stage within %0d cycles (at %0d ns)",
				pkt_q.size(), DRAIN_TIMEOUT, $time);
			err_other++;
		end
		repeat (4) step();
	endtask

	// scoreboard, sampled mid-cycle
	always @(negedge clk) begin
		if (!rst) begin
			if (issued_total == 0 && (ex_valid || issue_credit)) begin
				$display("ex_valid or issue_credit rose before any issue (at %0d ns)", $time);
				err_other++;
			end
			if (ex_valid) begin
				ex_sent++;
				ex_owed++;
				if (!have_pend) begin
					$display("ex_valid with no packet outstanding (at %0d ns)", $time);
					err_other++;
				end else begin
					check_tag("ex_rob_id", ex_rob_id, pend_tag);
					check_data("ex_data1", ex_data1, pend1.data);
					check_enable("ex_data1_e_", ex_data1_e_, pend1.data_e_);
					check_data("ex_data2", ex_data2, pend2.data);
					check_enable("ex_data2_e_", ex_data2_e_, pend2.data_e_);
					void'(pkt_q.pop_front());
				end
				if (ex_sent > `EX_CREDITS + ex_returned) begin
					$display("more packets sent than execution credits granted (at %0d ns)",
						$time);
					err_other++;
				end
			end
			if (ex_credit) begin
				ex_returned++;
			end
			if (issue_credit) begin
				issue_credits++;
				credit_pulses++;
			end
			// packets handed in but not yet sent must fit in the queue
			if (issued_total - ex_sent > `ISSUE_DEPTH) begin
				$display("issue queue holds more than %0d packets (at %0d ns)",
					`ISSUE_DEPTH, $time);
				err_other++;
			end
			// operands of the head if it leaves in this cycle
			have_pend = (pkt_q.size() != 0);
			if (have_pend) begin
				pend_tag = pkt_q[0].tag;
				pend1 = ref_operand(pkt_q[0].rs1, pkt_q[0].imm, pkt_q[0].pc);
				pend2 = ref_operand(pkt_q[0].rs2, pkt_q[0].imm, pkt_q[0].pc);
			end
			// commit lands in the register file at the next edge
			if (!commit_e_ && commit_rd.regtype == TYPE_GPR) begin
				gpr_shadow[commit_rd.addr] = commit_data;
			end
			if (!commit_e_ && commit_rd.regtype == TYPE_FPR) begin
				fpr_shadow[commit_rd.addr] = commit_data;
			end
		end
	end

	initial begin
		pkt_t p;
		lfsr = 16'd24412;
		for (int i = 0; i < `REG_COUNT; i++) begin
			gpr_shadow[i] = '0;
			fpr_shadow[i] = '0;
		end
		rst <= 1'b1;
		issue_valid <= 1'b0;
		issue_rs1 <= '0;
		issue_rs2 <= '0;
		issue_imm <= '0;
		issue_pc <= '0;
		issue_rob_id <= '0;
		wb_e_ <= 1'b1;
		wb_rob_id <= '0;
		wb_data <= '0;
		commit_e_ <= 1'b1;
		commit_rob_id <= '0;
		commit_rd <= '0;
		commit_data <= '0;
		ex_credit <= 1'b0;
		repeat (16) @(posedge clk);
		rst <= 1'b0;
		repeat (10) step();

		// gpr and fpr share addresses, only even slots get an fpr word
		for (int a = 0; a < 8; a++) begin
			commit_reg(TYPE_GPR, reg_addr_t'(a * 4 + 1), rand_bits(32));
			if (a % 2 == 0) begin
				commit_reg(TYPE_FPR, reg_addr_t'(a * 4 + 1), rand_bits(32));
			end
		end
		commit_reg(TYPE_GPR, reg_addr_t'(5), rand_bits(32));
		for (int a = 0; a < 8; a++) begin
			p = '0;
			p.rs1 = '{regtype: TYPE_GPR, addr: reg_addr_t'(a * 4 + 1)};
			p.rs2 = '{regtype: TYPE_FPR, addr: reg_addr_t'(a * 4 + 1)};
			p.tag = rob_id_t'(a);
			issue_pkt(p);
		end
		wait_drain();

		// every size, shift and sign, plain and with the field msbs set
		for (int s = 0; s < 4; s++) begin
			for (int h = 0; h < 3; h++) begin
				for (int g = 0; g < 4; g++) begin
					p = '0;
					p.rs1 = '{regtype: TYPE_IMM, addr: '0};
					p.rs2 = '{regtype: (g % 2 == 0) ? TYPE_PC : TYPE_NONE, addr: '0};
					p.imm.data = 20'(rand_bits(20));
					if (g >= 2) begin
						p.imm.data = p.imm.data | 20'h80810;
					end
					p.imm.size = imm_size_e'(2'(s));
					p.imm.shift = imm_shift_e'(2'(h));
					p.imm.sign = g[0];
					p.pc = rand_bits(32);
					p.tag = rob_id_t'(rand_bits(4));
					issue_pkt(p);
				end
			end
		end
		wait_drain();

		// tag 3 on writeback, tag 9 on commit, tag 12 nowhere
		step();
		wb_e_ <= 1'b0;
		wb_rob_id <= rob_id_t'(3);
		wb_data <= rand_bits(32);
		commit_e_ <= 1'b0;
		commit_rob_id <= rob_id_t'(9);
		commit_rd <= '{regtype: TYPE_NONE, addr: '0};
		commit_data <= rand_bits(32);
		for (int k = 0; k < 4; k++) begin
			p = '0;
			p.rs1 = '{regtype: TYPE_ROB, addr: reg_addr_t'((k < 2) ? 3 + 16 * k : 12)};
			p.rs2 = '{regtype: (k == 3) ? TYPE_GPR : TYPE_ROB,
				addr: reg_addr_t'((k == 2) ? 12 : 9 + 16 * (k % 2))};
			p.tag = rob_id_t'(k);
			issue_pkt(p);
		end
		wait_drain();
		step();
		wb_e_ <= 1'b1;
		commit_e_ <= 1'b1;

		// random traffic with bursty execution credits
		ex_random = 1'b1;
		byp_random = 1'b1;
		for (int n = 0; n < 150; n++) begin
			if (rand_bits(2) == 0) begin
				step();
			end
			p.rs1 = rand_src();
			p.rs2 = rand_src();
			p.imm = rand_imm();
			p.pc = rand_bits(32);
			p.tag = rob_id_t'(rand_bits(4));
			issue_pkt(p);
		end
		byp_random = 1'b0;
		step();
		wb_e_ <= 1'b1;
		commit_e_ <= 1'b1;
		commit_rd <= '{regtype: TYPE_NONE, addr: '0};
		wait_drain();
		ex_random = 1'b0;
		repeat (8) step();

		if (credit_pulses != ex_sent || ex_sent != issued_total) begin
			$display("%0d issued, %0d sent, %0d issue credits returned, counts differ",
				issued_total, ex_sent, credit_pulses);
			err_other++;
		end
		if (issue_credits != `ISSUE_DEPTH) begin
			$display("issuer ends with %0d credits instead of %0d", issue_credits, `ISSUE_DEPTH);
			err_other++;
		end
		$display("%0d packets checked, %0d value errors, %0d other errors",
			ex_sent, err_value, err_other);
		if (err_value == 0 && err_other == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

//--- design/opfetch_top.sv
/* operand-read stage, credit flow on both the issue and the execution side
   commit writes the gpr or fpr by commit_rd's type, writeback is bypass only */
`timescale 1ns/1ps

module opfetch_top import operand_pkg::*, pipe_pkg::*; (
	input logic			clk,
	input logic			rst,

	input logic			issue_valid,
	input reg_file_t	issue_rs1,
	input reg_file_t	issue_rs2,
	input imm_data_t	issue_imm,
	input data_t		issue_pc,
	input rob_id_t		issue_rob_id,
	output logic		issue_credit,

	input logic			wb_e_,
	input rob_id_t		wb_rob_id,
	input data_t		wb_data,

	input logic			commit_e_,
	input rob_id_t		commit_rob_id,
	input reg_file_t	commit_rd,
	input data_t		commit_data,

	input logic			ex_credit,
	output logic		ex_valid,
	output rob_id_t		ex_rob_id,
	output data_t		ex_data1,
	output logic		ex_data1_e_,
	output data_t		ex_data2,
	output logic		ex_data2_e_
);

	reg_addr_t	gpr_addr1;
	reg_addr_t	gpr_addr2;
	reg_addr_t	fpr_addr1;
	reg_addr_t	fpr_addr2;
	data_t		gpr_data1;
	data_t		gpr_data2;
	data_t		fpr_data1;
	data_t		fpr_data2;
	data_t		mux_data1;
	data_t		mux_data2;
	logic		mux_data1_e_;
	logic		mux_data2_e_;

	issue_if u_head ();

	issue_queue u_queue (
		.clk(clk), .rst(rst), .issue_valid(issue_valid),
		.issue_rs1(issue_rs1), .issue_rs2(issue_rs2), .issue_imm(issue_imm),
		.issue_pc(issue_pc), .issue_rob_id(issue_rob_id),
		.issue_credit(issue_credit), .head(u_head)
	);

	// operands are read straight from the queue head
	operand_mux u_mux (
		.issue_rs1(u_head.head_rs1), .issue_rs2(u_head.head_rs2),
		.issue_imm(u_head.head_imm), .pc(u_head.head_pc),
		.wb_e_(wb_e_), .wb_rob_id(wb_rob_id), .wb_data(wb_data),
		.commit_e_(commit_e_), .commit_rob_id(commit_rob_id), .commit_data(commit_data),
		.gpr_data1(gpr_data1), .gpr_data2(gpr_data2),
		.fpr_data1(fpr_data1), .fpr_data2(fpr_data2),
		.gpr_addr1(gpr_addr1), .gpr_addr2(gpr_addr2),
		.fpr_addr1(fpr_addr1), .fpr_addr2(fpr_addr2),
		.data1(mux_data1), .data2(mux_data2),
		.data1_e_(mux_data1_e_), .data2_e_(mux_data2_e_)
	);

	regfile u_gpr (
		.clk(clk), .rst(rst),
		.we(!commit_e_ && (commit_rd.regtype == TYPE_GPR)),
		.waddr(commit_rd.addr), .wdata(commit_data),
		.raddr1(gpr_addr1), .raddr2(gpr_addr2),
		.rdata1(gpr_data1), .rdata2(gpr_data2)
	);

	regfile u_fpr (
		.clk(clk), .rst(rst),
		.we(!commit_e_ && (commit_rd.regtype == TYPE_FPR)),
		.waddr(commit_rd.addr), .wdata(commit_data),
		.raddr1(fpr_addr1), .raddr2(fpr_addr2),
		.rdata1(fpr_data1), .rdata2(fpr_data2)
	);

	operand_stage u_stage (
		.clk(clk), .rst(rst), .head(u_head),
		.data1(mux_data1), .data2(mux_data2),
		.data1_e_(mux_data1_e_), .data2_e_(mux_data2_e_),
		.ex_credit(ex_credit), .ex_valid(ex_valid), .ex_rob_id(ex_rob_id),
		.ex_data1(ex_data1), .ex_data2(ex_data2),
		.ex_data1_e_(ex_data1_e_), .ex_data2_e_(ex_data2_e_)
	);

endmodule

//--- design/operand_stage.sv
/* registers one operand packet per execution credit
   ex outputs are meaningful only in the single cycle ex_valid is high */
`timescale 1ns/1ps
`include "opfetch_params.svh"

module operand_stage import pipe_pkg::*; (
	input logic		clk,
	input logic		rst,
	issue_if.stage	head,
	input data_t	data1,
	input data_t	data2,
	input logic		data1_e_,
	input logic		data2_e_,
	input logic		ex_credit,
	output logic	ex_valid,
	output rob_id_t	ex_rob_id,
	output data_t	ex_data1,
	output data_t	ex_data2,
	output logic	ex_data1_e_,
	output logic	ex_data2_e_
);

	credit_t	credits;
	logic		send;

	// head leaves only while a credit is held
	assign send = head.head_valid && (credits != '0);
	assign head.pop = send;

	// spend and return may land in the same cycle
	always_ff @(posedge clk) begin
		if (rst) begin
			credits <= credit_t'(`EX_CREDITS);
			ex_valid <= 1'b0;
		end else begin
			credits <= credits + credit_t'(ex_credit) - credit_t'(send);
			ex_valid <= send;
		end
	end

	// operands sampled from the mux in the send cycle
	always_ff @(posedge clk) begin
		if (send) begin
			ex_rob_id <= head.head_rob_id;
			ex_data1 <= data1;
			ex_data2 <= data2;
			ex_data1_e_ <= data1_e_;
			ex_data2_e_ <= data2_e_;
		end
	end

endmodule

//--- design/issue_queue.sv
/* circular FIFO for issue packets, no overflow guard
   the issuer must hold a credit for every packet, one credit comes back per pop */
`timescale 1ns/1ps
`include "opfetch_params.svh"

module issue_queue import operand_pkg::*, pipe_pkg::*; (
	input logic			clk,
	input logic			rst,
	input logic			issue_valid,
	input reg_file_t	issue_rs1,
	input reg_file_t	issue_rs2,
	input imm_data_t	issue_imm,
	input data_t		issue_pc,
	input rob_id_t		issue_rob_id,
	output logic		issue_credit,
	issue_if.queue		head
);

	typedef struct packed {
		reg_file_t	rs1;
		reg_file_t	rs2;
		imm_data_t	imm;
		data_t		pc;
		rob_id_t	rob_id;
	} entry_t;

	entry_t		mem [`ISSUE_DEPTH];
	qptr_t		wr_ptr;
	qptr_t		rd_ptr;
	credit_t	count;

	// pointers wrap on their own width
	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			issue_credit <= 1'b0;
		end else begin
			if (issue_valid) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (head.pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			count <= count + credit_t'(issue_valid) - credit_t'(head.pop);
			issue_credit <= head.pop;
		end
	end

	always_ff @(posedge clk) begin
		if (issue_valid) begin
			mem[wr_ptr] <= '{issue_rs1, issue_rs2, issue_imm, issue_pc, issue_rob_id};
		end
	end

	// new entry reaches the head one cycle after the push
	assign head.head_valid = (count != '0);
	assign head.head_rs1 = mem[rd_ptr].rs1;
	assign head.head_rs2 = mem[rd_ptr].rs2;
	assign head.head_imm = mem[rd_ptr].imm;
	assign head.head_pc = mem[rd_ptr].pc;
	assign head.head_rob_id = mem[rd_ptr].rob_id;

endmodule

//--- design/operand_mux.sv
/* purely combinational operand selection, no wakeup
   an unmatched rob source comes out disabled with zero data, wb and commit never share a tag */
`timescale 1ns/1ps

module operand_mux import operand_pkg::*, pipe_pkg::*; (
	input reg_file_t	issue_rs1,
	input reg_file_t	issue_rs2,
	input imm_data_t	issue_imm,
	input data_t		pc,

	input logic			wb_e_,
	input rob_id_t		wb_rob_id,
	input data_t		wb_data,

	input logic			commit_e_,
	input rob_id_t		commit_rob_id,
	input data_t		commit_data,

	input data_t		gpr_data1,
	input data_t		gpr_data2,
	input data_t		fpr_data1,
	input data_t		fpr_data2,
	output reg_addr_t	gpr_addr1,
	output reg_addr_t	gpr_addr2,
	output reg_addr_t	fpr_addr1,
	output reg_addr_t	fpr_addr2,

	output data_t		data1,
	output data_t		data2,
	output logic		data1_e_,
	output logic		data2_e_
);

	localparam int DW = $bits(data_t);
	localparam int TAG_W = $bits(rob_id_t);

	// data with its active-low enable
	typedef struct packed {
		data_t	data;
		logic	data_e_;
	} opnd_t;

	data_t	imm_ext5;
	data_t	imm_ext12;
	data_t	imm_ext20;
	data_t	imm_data;
	opnd_t	byp1;
	opnd_t	byp2;
	opnd_t	sel1;
	opnd_t	sel2;

	// writeback checked first, commit second
	function automatic opnd_t rob_bypass(
		input rob_id_t	tag,
		input logic		wb_en_,
		input rob_id_t	wb_tag,
		input data_t	wb_word,
		input logic		com_en_,
		input rob_id_t	com_tag,
		input data_t	com_word
	);
		opnd_t res;
		res = '{data: '0, data_e_: 1'b1};
		if (!wb_en_ && (tag == wb_tag)) begin
			res = '{data: wb_word, data_e_: 1'b0};
		end else if (!com_en_ && (tag == com_tag)) begin
			res = '{data: com_word, data_e_: 1'b0};
		end
		return res;
	endfunction

	function automatic opnd_t sel_operand(
		input reg_file_t	rs,
		input data_t		gpr,
		input data_t		fpr,
		input opnd_t		byp,
		input data_t		pc_word,
		input data_t		imm
	);
		opnd_t res;
		// none source gives zero, still enabled
		res = '{data: '0, data_e_: 1'b0};
		case (rs.regtype)
			TYPE_GPR: res.data = gpr;
			TYPE_FPR: res.data = fpr;
			TYPE_IMM: res.data = imm;
			TYPE_PC: res.data = pc_word;
			TYPE_ROB: res = byp;
			default: res.data = '0;
		endcase
		return res;
	endfunction

	// read ports idle at zero unless used
	assign gpr_addr1 = (issue_rs1.regtype == TYPE_GPR) ? issue_rs1.addr : '0;
	assign gpr_addr2 = (issue_rs2.regtype == TYPE_GPR) ? issue_rs2.addr : '0;
	assign fpr_addr1 = (issue_rs1.regtype == TYPE_FPR) ? issue_rs1.addr : '0;
	assign fpr_addr2 = (issue_rs2.regtype == TYPE_FPR) ? issue_rs2.addr : '0;

	assign byp1 = rob_bypass(issue_rs1.addr[TAG_W-1:0], wb_e_, wb_rob_id, wb_data,
		commit_e_, commit_rob_id, commit_data);
	assign byp2 = rob_bypass(issue_rs2.addr[TAG_W-1:0], wb_e_, wb_rob_id, wb_data,
		commit_e_, commit_rob_id, commit_data);

	assign sel1 = sel_operand(issue_rs1, gpr_data1, fpr_data1, byp1, pc, imm_data);
	assign sel2 = sel_operand(issue_rs2, gpr_data2, fpr_data2, byp2, pc, imm_data);

	assign data1 = sel1.data;
	assign data1_e_ = sel1.data_e_;
	assign data2 = sel2.data;
	assign data2_e_ = sel2.data_e_;

	// extend first, then shift into place
	assign imm_ext5 = {{(DW-5){issue_imm.sign & issue_imm.data[4]}}, issue_imm.data[4:0]};
	assign imm_ext12 = {{(DW-12){issue_imm.sign & issue_imm.data[11]}}, issue_imm.data[11:0]};
	assign imm_ext20 = {{(DW-20){issue_imm.sign & issue_imm.data[19]}}, issue_imm.data};

	always_comb begin
		case (issue_imm.size)
			IMM_SIZE5: imm_data = imm_ext5;
			IMM_SIZE12: imm_data = (issue_imm.shift == IMM_SHIFT1) ? imm_ext12 << 1 : imm_ext12;
			// branch offsets shift by one, upper immediates by twelve
			IMM_SIZE20: imm_data = (issue_imm.shift == IMM_SHIFT1) ? imm_ext20 << 1 : imm_ext20 << 12;
			// csr form left packed for a later unpack
			default: imm_data = {{(DW-20){1'b0}}, issue_imm.data};
		endcase
	end

endmodule

//--- design/regfile.sv
/* two asynchronous read ports, one synchronous write port
   a read in the write cycle returns the old word */
`timescale 1ns/1ps
`include "opfetch_params.svh"

module regfile import operand_pkg::*, pipe_pkg::*; (
	input logic			clk,
	input logic			rst,
	input logic			we,
	input reg_addr_t	waddr,
	input data_t		wdata,
	input reg_addr_t	raddr1,
	input reg_addr_t	raddr2,
	output data_t		rdata1,
	output data_t		rdata2
);

	data_t regs [`REG_COUNT];

	// all words come up as zero
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < `REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else if (we) begin
			regs[waddr] <= wdata;
		end
	end

	assign rdata1 = regs[raddr1];
	assign rdata2 = regs[raddr2];

endmodule

//--- design/issue_if.sv
/* head of the issue queue as seen by the output stage
   pop is only legal in a cycle where head_valid is high */
`timescale 1ns/1ps

interface issue_if import operand_pkg::*, pipe_pkg::*;;

	// oldest queued packet
	logic		head_valid;
	reg_file_t	head_rs1;
	reg_file_t	head_rs2;
	imm_data_t	head_imm;
	data_t		head_pc;
	rob_id_t	head_rob_id;

	// retire the head entry
	logic		pop;

	modport queue (
		output head_valid,
		output head_rs1,
		output head_rs2,
		output head_imm,
		output head_pc,
		output head_rob_id,
		input pop
	);

	// operand sources go to the mux at the top level
	modport stage (
		input head_valid,
		input head_rob_id,
		output pop
	);

endinterface

//--- design/pipe_pkg.sv
/* pipeline control types, all widths derived from the sizing macros */
`include "opfetch_params.svh"

package pipe_pkg;

	// one operand word
	typedef logic [`DATA_WIDTH-1:0] data_t;

	// reorder buffer tag
	typedef logic [$clog2(`ROB_DEPTH)-1:0] rob_id_t;

	// holds 0 up to ISSUE_DEPTH inclusive
	typedef logic [$clog2(`ISSUE_DEPTH):0] credit_t;

	// slot index into the issue queue
	typedef logic [$clog2(`ISSUE_DEPTH)-1:0] qptr_t;

endpackage

//--- design/operand_pkg.sv
/* operand encoding types shared by the issuer and the operand-read stage
   a rob source carries its tag in the low bits of the register address */
`include "opfetch_params.svh"

package operand_pkg;

	// where an operand comes from
	typedef enum logic [2:0] {
		TYPE_NONE,
		TYPE_GPR,
		TYPE_FPR,
		TYPE_IMM,
		TYPE_PC,
		TYPE_ROB
	} reg_type_e;

	typedef logic [$clog2(`REG_COUNT)-1:0] reg_addr_t;

	typedef struct packed {
		reg_type_e	regtype;
		reg_addr_t	addr;
	} reg_file_t;

	// raw immediate field widths
	typedef enum logic [1:0] {
		IMM_SIZE5,
		IMM_SIZE5_12,
		IMM_SIZE12,
		IMM_SIZE20
	} imm_size_e;

	typedef enum logic [1:0] {
		IMM_SHIFT0,
		IMM_SHIFT1,
		IMM_SHIFT12
	} imm_shift_e;

	// sign set means sign extension, clear means zero extension
	typedef struct packed {
		logic [19:0]	data;
		imm_size_e		size;
		imm_shift_e		shift;
		logic			sign;
	} imm_data_t;

endpackage

//--- design/opfetch_params.svh
/* core sizing macros
   ISSUE_DEPTH must be a power of two, since the queue pointers wrap on their own width */
`ifndef OPFETCH_PARAMS_SVH
`define OPFETCH_PARAMS_SVH

// operand word width
`define DATA_WIDTH	32

// reorder buffer entries, tag width follows
`define ROB_DEPTH	16

// entries per register file (gpr and fpr alike)
`define REG_COUNT	32

// issue queue slots, equals the issuer's starting credits
`define ISSUE_DEPTH	4

// credits the execution side grants after reset
`define EX_CREDITS	2

`endif
